/* logic/bridge_pkg.sv */
//--------------------------------------------------------------------------
// shared definitions for the byte-serial block bridge
// bus and byte types, read response codes, data address,
// block geometry and the load sequencer states
//--------------------------------------------------------------------------

package bridge_pkg;

	typedef logic [7:0]  byte_t;	// one data byte
	typedef logic [31:0] word_t;	// bus word, address or data
	typedef logic [1:0]  resp_t;	// read response

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// single word the master writes key/plaintext to and reads results from
	localparam word_t DATA_ADDR = 32'h0000_0510;

	localparam int BLOCK_BYTES  = 16;	// 128-bit block, one byte per beat
	localparam int NUM_IN_FIFOS = 2;	// key and plaintext
	localparam int KEY_IDX      = 0;
	localparam int TEXT_IDX     = 1;

	// block flow through the bridge
	typedef enum logic [1:0] {
		COLLECT_KEY,	// filling key fifo
		COLLECT_TEXT,	// filling plaintext fifo
		STREAM,		// mixing into output fifo
		READOUT		// master drains results
	} seq_state_t;

endpackage

/* logic/byte_fifo.sv */
//--------------------------------------------------------------------------
// synchronous byte fifo, first word fall through
// full/empty from extended pointer compare
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module byte_fifo
	import bridge_pkg::*;
#(
	parameter int DEPTH = 16	// power of two
)
(
	input  logic  clk_main_a0,
	input  logic  rst_main_n_sync,
	input  logic  push,
	input  byte_t din,
	input  logic  pop,
	output byte_t dout,
	output logic  full,
	output logic  empty
);

	localparam int AW = $clog2(DEPTH);

	byte_t       mem [DEPTH];
	logic [AW:0] wr_ptr;	// msb is the wrap bit
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	// same slot, opposite lap -> full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);

	assign do_push = push && !full;		// overflow dropped
	assign do_pop  = pop && !empty;		// underflow ignored

	assign dout = mem[rd_ptr[AW-1:0]];	// head visible without a read cycle

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk_main_a0)
	begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= din;
	end

endmodule

/* logic/load_sequencer.sv */
//--------------------------------------------------------------------------
// load sequencer
// write address decode, steering of bytes into key/plaintext fifos,
// block state machine driving stream and readout levels
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module load_sequencer
	import bridge_pkg::*;
(
	input  logic                    clk_main_a0,
	input  logic                    rst_main_n_sync,
	input  logic                    wready,
	input  word_t                   wr_addr,
	input  word_t                   wdata,
	input  logic [NUM_IN_FIFOS-1:0] in_full,
	input  logic                    out_full,
	input  logic                    out_empty,
	output logic [NUM_IN_FIFOS-1:0] in_push,
	output byte_t                   in_din,
	output logic                    stream_en,
	output logic                    result_ready
);

	// bytes steered so far in this block, 0 .. 2*BLOCK_BYTES
	localparam int CNT_W = $clog2(2 * BLOCK_BYTES) + 1;
	localparam logic [CNT_W-1:0] KEY_END  = CNT_W'(BLOCK_BYTES);
	localparam logic [CNT_W-1:0] TEXT_END = CNT_W'(2 * BLOCK_BYTES);

	seq_state_t       state;
	seq_state_t       state_next;
	logic [CNT_W-1:0] load_cnt;
	logic             wr_hit;
	logic             collecting;
	logic             to_key;
	logic             to_text;

	assign wr_hit     = wready && (wr_addr == DATA_ADDR);	// accepted write
	assign collecting = (state == COLLECT_KEY) || (state == COLLECT_TEXT);

	// push lands a cycle late, so full lags the byte count by up to two
	// edges; the count decides the target and keeps back-to-back writes
	// from spilling the first plaintext bytes into the full key fifo
	assign to_key  = wr_hit && collecting && (load_cnt < KEY_END);
	assign to_text = wr_hit && collecting && (load_cnt >= KEY_END) && (load_cnt < TEXT_END);

	assign stream_en    = (state == STREAM);
	assign result_ready = (state == READOUT) && !out_empty;	// a result byte is waiting

	//----------------------------------------------------------------------
	// next state
	//----------------------------------------------------------------------
	always_comb
	begin
		state_next = state;
		case (state)
			COLLECT_KEY:
				if (in_full[KEY_IDX])
					state_next = COLLECT_TEXT;
			COLLECT_TEXT:
				if (in_full[TEXT_IDX])
					state_next = STREAM;
			STREAM:
				if (out_full)	// whole block mixed
					state_next = READOUT;
			READOUT:
				if (out_empty)	// master took the last byte
					state_next = COLLECT_KEY;
			default:
				state_next = COLLECT_KEY;
		endcase
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state    <= COLLECT_KEY;
			load_cnt <= '0;
			in_push  <= '0;
		end
		else
		begin
			state              <= state_next;
			in_push            <= '0;
			in_push[KEY_IDX]   <= to_key;		// registered strobes
			in_push[TEXT_IDX]  <= to_text;
			if (!collecting)
				load_cnt <= '0;			// fresh block next time
			else if (to_key || to_text)
				load_cnt <= load_cnt + 1'b1;
		end
	end

	// shared byte for both input fifos, only low byte of the word is used
	always_ff @(posedge clk_main_a0)
	begin
		if (to_key || to_text)
			in_din <= wdata[7:0];
	end

endmodule

/* logic/round_key_mixer.sv */
//--------------------------------------------------------------------------
// round key mixer
// lockstep pop of key/plaintext fifos, registered xor into output fifo
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module round_key_mixer
	import bridge_pkg::*;
(
	input  logic  clk_main_a0,
	input  logic  rst_main_n_sync,
	input  logic  stream_en,
	input  byte_t key_byte,
	input  byte_t text_byte,
	input  logic  key_empty,
	input  logic  text_empty,
	output logic  in_pop,
	output logic  out_push,
	output byte_t out_byte
);

	// one pop strobe serves both fifos, counts stay equal
	assign in_pop = stream_en && !key_empty && !text_empty;

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
			out_push <= 1'b0;
		else
			out_push <= in_pop;	// valid follows the popped pair
	end

	// addroundkey on one byte
	always_ff @(posedge clk_main_a0)
	begin
		if (in_pop)
			out_byte <= key_byte ^ text_byte;
	end

endmodule

/* logic/read_port.sv */
//--------------------------------------------------------------------------
// read port
// one registered response at a time, okay with result byte or slverr
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module read_port
	import bridge_pkg::*;
(
	input  logic  clk_main_a0,
	input  logic  rst_main_n_sync,
	input  logic  arvalid_q,
	input  word_t araddr_q,
	input  logic  rready,
	input  logic  result_ready,
	input  byte_t head_byte,
	output logic  pop,
	output logic  rvalid,
	output word_t rdata,
	output resp_t rresp
);

	logic take;	// request sampled this edge
	logic good;	// request that returns a result byte

	assign take = arvalid_q && !rvalid;	// no new request while a response is out
	assign good = take && (araddr_q == DATA_ADDR) && result_ready;
	assign pop  = good;			// head leaves the output fifo with the request

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= RESP_OKAY;
		end
		else if (take)
		begin
			rvalid <= 1'b1;
			rdata  <= good ? word_t'(head_byte) : '0;	// zero extended
			rresp  <= good ? RESP_OKAY : RESP_SLVERR;
		end
		else if (rvalid && rready)
			rvalid <= 1'b0;		// data/resp keep their last value
	end

endmodule

/* logic/fifo_bridge_top.sv */
//--------------------------------------------------------------------------
// fifo bridge top level
// load sequencer, key/plaintext fifos, round key mixer,
// output fifo and read port
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_bridge_top
	import bridge_pkg::*;
(
	input  logic  clk_main_a0,
	input  logic  rst_main_n_sync,
	input  logic  wready,
	input  word_t wr_addr,
	input  word_t wdata,
	input  logic  arvalid_q,
	input  word_t araddr_q,
	input  logic  rready,
	output logic  rvalid,
	output word_t rdata,
	output resp_t rresp
);

	// input side
	logic [NUM_IN_FIFOS-1:0] in_push;
	logic [NUM_IN_FIFOS-1:0] in_full;
	logic [NUM_IN_FIFOS-1:0] in_empty;
	byte_t                   in_dout [NUM_IN_FIFOS];
	byte_t                   in_din;
	logic                    in_pop;	// shared by both input fifos

	// block control
	logic  stream_en;
	logic  result_ready;

	// output side
	logic  out_push;
	logic  out_pop;
	logic  out_full;
	logic  out_empty;
	byte_t mix_byte;
	byte_t head_byte;

	load_sequencer u_load_sequencer (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wready          (wready),
		.wr_addr         (wr_addr),
		.wdata           (wdata),
		.in_full         (in_full),
		.out_full        (out_full),
		.out_empty       (out_empty),
		.in_push         (in_push),
		.in_din          (in_din),
		.stream_en       (stream_en),
		.result_ready    (result_ready)
	);

	//----------------------------------------------------------------------
	// key and plaintext fifos
	//----------------------------------------------------------------------
	generate
		for (genvar i = 0; i < NUM_IN_FIFOS; i++)
		begin : g_in_fifo
			byte_fifo #(
				.DEPTH (BLOCK_BYTES)
			) u_in_fifo (
				.clk_main_a0     (clk_main_a0),
				.rst_main_n_sync (rst_main_n_sync),
				.push            (in_push[i]),
				.din             (in_din),
				.pop             (in_pop),
				.dout            (in_dout[i]),
				.full            (in_full[i]),
				.empty           (in_empty[i])
			);
		end
	endgenerate

	round_key_mixer u_round_key_mixer (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.stream_en       (stream_en),
		.key_byte        (in_dout[KEY_IDX]),
		.text_byte       (in_dout[TEXT_IDX]),
		.key_empty       (in_empty[KEY_IDX]),
		.text_empty      (in_empty[TEXT_IDX]),
		.in_pop          (in_pop),
		.out_push        (out_push),
		.out_byte        (mix_byte)
	);

	// result fifo, block deep so the mixer never stalls
	byte_fifo #(
		.DEPTH (BLOCK_BYTES)
	) u_out_fifo (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (out_push),
		.din             (mix_byte),
		.pop             (out_pop),
		.dout            (head_byte),
		.full            (out_full),
		.empty           (out_empty)
	);

	read_port u_read_port (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.result_ready    (result_ready),
		.head_byte       (head_byte),
		.pop             (out_pop),
		.rvalid          (rvalid),
		.rdata           (rdata),
		.rresp           (rresp)
	);

endmodule

/* testbench/fifo_bridge_assert.sv */
//--------------------------------------------------------------------------
// concurrent assertions on the read port, bound into read_port
// response stability under back-pressure, reset state, pop qualification
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_bridge_assert
	import bridge_pkg::*;
(
	input logic  clk_main_a0,
	input logic  rst_main_n_sync,
	input logic  rvalid,
	input logic  rready,
	input word_t rdata,
	input resp_t rresp,
	input logic  pop,
	input logic  result_ready
);

	// stalled response keeps valid, data and code
	a_resp_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
		else $error("read response changed while rready was low");

	a_reset_idle: assert property (@(posedge clk_main_a0)
		!rst_main_n_sync |=> !rvalid)
		else $error("rvalid high right after reset");

	// an okay response only follows a result byte popped with result_ready
	a_okay_popped: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		($rose(rvalid) && (rresp == RESP_OKAY)) |-> $past(pop && result_ready))
		else $error("okay response without a popped result byte");

endmodule

bind read_port fifo_bridge_assert u_read_assert (
	.clk_main_a0     (clk_main_a0),
	.rst_main_n_sync (rst_main_n_sync),
	.rvalid          (rvalid),
	.rready          (rready),
	.rdata           (rdata),
	.rresp           (rresp),
	.pop             (pop),
	.result_ready    (result_ready)
);

/* testbench/tb_fifo_bridge.sv */
//--------------------------------------------------------------------------
// testbench for the byte-serial block bridge
// clock and reset, trace-driven key/plaintext loading with junk writes,
// result readback with random rready stalls, checks and timeout
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_fifo_bridge
	import bridge_pkg::*;
();

	localparam int    NUM_BLOCKS     = 2;
	localparam int    TRACE_COLS     = 3;			// key, plaintext, expected
	localparam int    TIMEOUT_CYCLES = NUM_BLOCKS * 200;
	localparam word_t OTHER_ADDR     = DATA_ADDR + 32'h4;	// any address but the bridge

	logic  clk_main_a0 = 1'b0;
	logic  rst_main_n_sync;
	logic  wready;
	word_t wr_addr;
	word_t wdata;
	logic  arvalid_q;
	word_t araddr_q;
	logic  rready;
	logic  rvalid;
	word_t rdata;
	resp_t rresp;

	byte_t trace_mem [NUM_BLOCKS * BLOCK_BYTES * TRACE_COLS];
	int    seed      = 62142;
	int    cycle_cnt = 0;

	fifo_bridge_top uut (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wready          (wready),
		.wr_addr         (wr_addr),
		.wdata           (wdata),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.rvalid          (rvalid),
		.rdata           (rdata),
		.rresp           (rresp)
	);

	always #50 clk_main_a0 = ~clk_main_a0;	// 100 ns period

	// run limit, roughly 200 cycles per block
	always @(posedge clk_main_a0)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$fatal(1, "run limit reached");
		end
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	//----------------------------------------------------------------------
	// bus tasks, entered and left 1 ns after a rising edge
	//----------------------------------------------------------------------
	task automatic write_word(input logic ready, input word_t addr, input word_t data);
		wready  = ready;
		wr_addr = addr;
		wdata   = data;
		@(posedge clk_main_a0);
		#1;
		wready  = 1'b0;
		wr_addr = '0;
		wdata   = '0;
	endtask

	// write that the bridge has to ignore
	task automatic write_junk(input int kind);
		word_t junk;
		junk = $random(seed);
		if (kind == 0)
			write_word(1'b0, DATA_ADDR, junk);	// strobe low
		else
			write_word(1'b1, OTHER_ADDR, junk);	// wrong address
	endtask

	task automatic read_word(input word_t addr, output word_t data, output resp_t resp);
		int stall;
		arvalid_q = 1'b1;
		araddr_q  = addr;
		@(posedge clk_main_a0);
		#1;
		arvalid_q = 1'b0;
		araddr_q  = '0;
		while (!rvalid)
		begin
			@(posedge clk_main_a0);
			#1;
		end
		data  = rdata;
		resp  = rresp;
		stall = $unsigned($random(seed)) % 4;	// 0..3 cycles of back-pressure
		repeat (stall)
		begin
			@(posedge clk_main_a0);
			#1;
			check_value("rvalid", word_t'(rvalid), 32'h1);	// response must wait for rready
			check_value("rdata", rdata, data);
			check_value("rresp", word_t'(rresp), word_t'(resp));
		end
		rready = 1'b1;
		@(posedge clk_main_a0);
		#1;
		rready = 1'b0;
		check_value("rvalid", word_t'(rvalid), 32'h0);	// dropped after acceptance
	endtask

	//----------------------------------------------------------------------
	// block level sequences
	//----------------------------------------------------------------------
	// 16 key bytes then 16 plaintext bytes, junk writes mixed in
	task automatic load_block(input int blk);
		int    base;
		word_t w;
		base = blk * BLOCK_BYTES * TRACE_COLS;
		for (int i = 0; i < 2 * BLOCK_BYTES; i++)
		begin
			if (i % 5 == 2)
				write_junk(i % 2);
			w = $random(seed);			// upper bytes are don't care
			if (i < BLOCK_BYTES)
				w[7:0] = trace_mem[base + i * TRACE_COLS];
			else
				w[7:0] = trace_mem[base + (i - BLOCK_BYTES) * TRACE_COLS + 1];
			write_word(1'b1, DATA_ADDR, w);
		end
	endtask

	// poll the data address until streaming is over
	task automatic wait_first_result(output word_t data, output resp_t resp);
		read_word(DATA_ADDR, data, resp);
		while (resp != RESP_OKAY)
		begin
			check_value("rresp", word_t'(resp), word_t'(RESP_SLVERR));
			check_value("rdata", data, 32'h0);
			read_word(DATA_ADDR, data, resp);
		end
	endtask

	task automatic drain_block(input int blk);
		int    base;
		word_t data;
		resp_t resp;
		byte_t key;
		byte_t text;
		byte_t exp_byte;
		base = blk * BLOCK_BYTES * TRACE_COLS;
		wait_first_result(data, resp);
		for (int i = 0; i < BLOCK_BYTES; i++)
		begin
			key      = trace_mem[base + i * TRACE_COLS];
			text     = trace_mem[base + i * TRACE_COLS + 1];
			exp_byte = trace_mem[base + i * TRACE_COLS + 2];
			check_value("trace expected", word_t'(exp_byte), word_t'(key ^ text));
			if (i > 0)
			begin
				if (i == 5)
				begin
					// foreign read mid readout, must not pop
					read_word(OTHER_ADDR, data, resp);
					check_value("rresp", word_t'(resp), word_t'(RESP_SLVERR));
					check_value("rdata", data, 32'h0);
				end
				read_word(DATA_ADDR, data, resp);
			end
			check_value("rresp", word_t'(resp), word_t'(RESP_OKAY));
			check_value("rdata", data, word_t'(exp_byte));
		end
	endtask

	//----------------------------------------------------------------------
	// main sequence
	//----------------------------------------------------------------------
	initial
	begin
		word_t data;
		resp_t resp;
		rst_main_n_sync = 1'b0;
		wready          = 1'b0;
		wr_addr         = '0;
		wdata           = '0;
		arvalid_q       = 1'b0;
		araddr_q        = '0;
		rready          = 1'b0;
		$readmemh("testbench/fifo_bridge_trace.txt", trace_mem);

		repeat (16) @(posedge clk_main_a0);
		#1;
		rst_main_n_sync = 1'b1;

		// idle read channel out of reset
		check_value("rvalid", word_t'(rvalid), 32'h0);
		check_value("rresp", word_t'(rresp), word_t'(RESP_OKAY));
		check_value("rdata", rdata, 32'h0);

		for (int blk = 0; blk < NUM_BLOCKS; blk++)
		begin
			read_word(DATA_ADDR, data, resp);	// nothing loaded yet
			check_value("rresp", word_t'(resp), word_t'(RESP_SLVERR));
			check_value("rdata", data, 32'h0);
			load_block(blk);
			drain_block(blk);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* testbench/fifo_bridge_trace.txt */
// columns: key byte, plaintext byte, expected result (key xor plaintext), all hex
// one line per byte position in arrival order, 16 lines per block
// block 0
2b 32 19
7e 43 3d
15 f6 e3
16 a8 be
28 88 a0
ae 5a f4
d2 30 e2
a6 8d 2b
ab 31 9a
f7 31 c6
15 98 8d
88 a2 2a
09 e0 e9
cf 37 f8
4f 07 48
3c 34 08
// block 1
00 00 00
01 11 10
02 22 20
03 33 30
04 44 40
05 55 50
06 66 60
07 77 70
08 88 80
09 99 90
0a aa a0
0b bb b0
0c cc c0
0d dd d0
0e ee e0
0f ff f0

/* fifo_bridge_top.f */
logic/bridge_pkg.sv
logic/byte_fifo.sv
logic/load_sequencer.sv
logic/round_key_mixer.sv
logic/read_port.sv
logic/fifo_bridge_top.sv
testbench/fifo_bridge_assert.sv
testbench/tb_fifo_bridge.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fifo_bridge
FILELIST = fifo_bridge_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
